// ==== alu_controller.sv ====
// four-state sequencer with instruction latch, program counter and decode, used inside cpu_core
`timescale 1ns/100ps
`include "cpu_macros.svh"

module alu_controller (
  input  logic                              clock,
  input  logic                              reset,
  input  logic [`CPU_DATA_WIDTH-1:0]        instruction,
  output logic                              fetch,
  output logic                              execute_enable,
  output logic                              writeback_enable,
  output logic                              write_enable,
  output logic [`CPU_DATA_WIDTH-1:0]        pc,
  output logic [`CPU_REG_ADDR_WIDTH-1:0]    read_address_a,
  output logic [`CPU_REG_ADDR_WIDTH-1:0]    read_address_b,
  output logic [`CPU_REG_ADDR_WIDTH-1:0]    write_address,
  output cpu_pkg::opcode_t                  operation,
  output cpu_pkg::sub_opcode_t              sub_operation,
  output logic [`CPU_IMM_WIDTH-1:0]         immediate_field,
  output cpu_pkg::imm_kind_t                imm_kind,
  output logic                              use_immediate,
  output cpu_pkg::wb_source_t               wb_source
);

  cpu_pkg::state_t state;
  cpu_pkg::state_t next_state;
  logic [`CPU_DATA_WIDTH-1:0] instruction_reg;
  logic write_valid;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= cpu_pkg::state_stop;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    unique case (state)
      cpu_pkg::state_stop:    next_state = cpu_pkg::state_fetch;
      cpu_pkg::state_fetch:   next_state = cpu_pkg::state_execute;
      cpu_pkg::state_execute: next_state = cpu_pkg::state_write;
      cpu_pkg::state_write:   next_state = cpu_pkg::state_stop;
    endcase
  end

  assign fetch            = (state == cpu_pkg::state_fetch);
  assign execute_enable   = (state == cpu_pkg::state_execute);
  assign writeback_enable = (state == cpu_pkg::state_write);

  // word is held by the outside while fetch is high
  always_ff @(posedge clock) begin
    if (fetch) begin
      instruction_reg <= instruction;
    end
  end

  // next address once the current instruction retires
  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= '0;
    end else if (writeback_enable) begin
      pc <= pc + `CPU_DATA_WIDTH'(4);
    end
  end

  assign operation       = cpu_pkg::opcode_t'(instruction_reg[30:25]);
  assign write_address   = instruction_reg[24:20];
  assign read_address_a  = instruction_reg[19:15];
  assign read_address_b  = instruction_reg[14:10];
  assign sub_operation   = cpu_pkg::sub_opcode_t'(instruction_reg[4:0]);
  assign immediate_field = instruction_reg[`CPU_IMM_WIDTH-1:0];

  always_comb begin
    imm_kind      = cpu_pkg::imm_5_ze;
    use_immediate = 1'b0;
    wb_source     = cpu_pkg::wb_alu;
    write_valid   = 1'b0;
    case (operation)
      cpu_pkg::op_alu: begin
        case (sub_operation)
          // shift amount comes from the zero-extended 5-bit field
          cpu_pkg::sub_slli, cpu_pkg::sub_srli, cpu_pkg::sub_rotri: begin
            use_immediate = 1'b1;
            write_valid   = 1'b1;
          end
          cpu_pkg::sub_add, cpu_pkg::sub_sub, cpu_pkg::sub_and,
          cpu_pkg::sub_xor, cpu_pkg::sub_or: begin
            write_valid = 1'b1;
          end
          default: begin
            write_valid = 1'b0;
          end
        endcase
      end
      cpu_pkg::op_addi: begin
        imm_kind      = cpu_pkg::imm_15_se;
        use_immediate = 1'b1;
        write_valid   = 1'b1;
      end
      cpu_pkg::op_ori, cpu_pkg::op_xori: begin
        imm_kind      = cpu_pkg::imm_15_ze;
        use_immediate = 1'b1;
        write_valid   = 1'b1;
      end
      cpu_pkg::op_movi: begin
        imm_kind      = cpu_pkg::imm_20_se;
        use_immediate = 1'b1;
        wb_source     = cpu_pkg::wb_immediate;
        write_valid   = 1'b1;
      end
      default: begin
        write_valid = 1'b0;
      end
    endcase
  end

  // undefined encodings run all four cycles but never write
  assign write_enable = writeback_enable && write_valid;

endmodule

// ==== cpu_core.sv ====
// top level of the multicycle core joining controller, register file and execute unit
`timescale 1ns/100ps
`include "cpu_macros.svh"

module cpu_core (
  input  logic                           clock,
  input  logic                           reset,
  input  logic [`CPU_DATA_WIDTH-1:0]     instruction,
  output logic                           fetch,
  output logic [`CPU_DATA_WIDTH-1:0]     pc,
  output logic                           write_enable,
  output logic [`CPU_REG_ADDR_WIDTH-1:0] write_address,
  output logic [`CPU_DATA_WIDTH-1:0]     write_data
);

  logic                           execute_enable;
  logic                           writeback_enable;
  logic [`CPU_REG_ADDR_WIDTH-1:0] read_address_a;
  logic [`CPU_REG_ADDR_WIDTH-1:0] read_address_b;
  cpu_pkg::opcode_t               operation;
  cpu_pkg::sub_opcode_t           sub_operation;
  logic [`CPU_IMM_WIDTH-1:0]      immediate_field;
  cpu_pkg::imm_kind_t             imm_kind;
  logic                           use_immediate;
  cpu_pkg::wb_source_t            wb_source;
  logic [`CPU_DATA_WIDTH-1:0]     read_data_a;
  logic [`CPU_DATA_WIDTH-1:0]     read_data_b;

  alu_controller u_controller (
    .clock            (clock),
    .reset            (reset),
    .instruction      (instruction),
    .fetch            (fetch),
    .execute_enable   (execute_enable),
    .writeback_enable (writeback_enable),
    .write_enable     (write_enable),
    .pc               (pc),
    .read_address_a   (read_address_a),
    .read_address_b   (read_address_b),
    .write_address    (write_address),
    .operation        (operation),
    .sub_operation    (sub_operation),
    .immediate_field  (immediate_field),
    .imm_kind         (imm_kind),
    .use_immediate    (use_immediate),
    .wb_source        (wb_source)
  );

  register_file u_register_file (
    .clock          (clock),
    .reset          (reset),
    .write_enable   (write_enable),
    .read_address_a (read_address_a),
    .read_address_b (read_address_b),
    .write_address  (write_address),
    .write_data     (write_data),
    .read_data_a    (read_data_a),
    .read_data_b    (read_data_b)
  );

  // the result register is the write-back value
  execute_unit u_execute_unit (
    .clock           (clock),
    .reset           (reset),
    .execute_enable  (execute_enable),
    .operation       (operation),
    .sub_operation   (sub_operation),
    .immediate_field (immediate_field),
    .imm_kind        (imm_kind),
    .use_immediate   (use_immediate),
    .wb_source       (wb_source),
    .read_data_a     (read_data_a),
    .read_data_b     (read_data_b),
    .result          (write_data)
  );

endmodule

// ==== cpu_core_assert.sv ====
// concurrent checks on the controller phase strobes, attached to cpu_core by bind
`timescale 1ns/100ps

module cpu_core_assert (
  input logic clock,
  input logic reset,
  input logic fetch,
  input logic execute_enable,
  input logic writeback_enable,
  input logic write_enable
);

  int         failure_count = 0;
  logic [2:0] phase;
  logic [2:0] phase_next;

  assign phase = {writeback_enable, execute_enable, fetch};
  // stop, fetch, execute, write, then stop again
  assign phase_next = {phase[1], phase[0], (phase == 3'b000)};

  sequence_order: assert property (@(posedge clock) disable iff (reset)
    1'b1 |=> phase == $past(phase_next))
  else begin
    failure_count++;
    $error("phase sequence broken, phase %b", phase);
  end

  one_phase: assert property (@(posedge clock) disable iff (reset) $onehot0(phase))
  else begin
    failure_count++;
    $error("more than one phase strobe high, phase %b", phase);
  end

  write_gated: assert property (@(posedge clock) disable iff (reset)
    write_enable |-> writeback_enable)
  else begin
    failure_count++;
    $error("write_enable high outside the write state");
  end

endmodule

bind cpu_core cpu_core_assert u_assert (
  .clock            (clock),
  .reset            (reset),
  .fetch            (fetch),
  .execute_enable   (execute_enable),
  .writeback_enable (writeback_enable),
  .write_enable     (write_enable)
);

// ==== cpu_macros.svh ====
// width and size constants for the multicycle core, included by every RTL file that sizes a port
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// register and instruction word width
`define CPU_DATA_WIDTH 32

// register address width, also the width of the shift amount field
`define CPU_REG_ADDR_WIDTH 5

// number of general purpose registers
`define CPU_REG_COUNT 32

// raw immediate field carried from the instruction, bits 19..0
`define CPU_IMM_WIDTH 20

`endif

// ==== cpu_pkg.sv ====
// shared enum types of the multicycle core, referenced by scoped name from the RTL and testbench
package cpu_pkg;

  // controller sequence, one cycle per state
  typedef enum logic [1:0] {
    state_stop    = 2'b00,
    state_fetch   = 2'b01,
    state_execute = 2'b10,
    state_write   = 2'b11
  } state_t;

  // major opcode, instruction bits 30..25
  typedef enum logic [5:0] {
    op_alu  = 6'b100000,
    op_movi = 6'b100010,
    op_addi = 6'b101000,
    op_xori = 6'b101011,
    op_ori  = 6'b101100
  } opcode_t;

  // alu group function, instruction bits 4..0
  typedef enum logic [4:0] {
    sub_add   = 5'b00000,
    sub_sub   = 5'b00001,
    sub_and   = 5'b00010,
    sub_xor   = 5'b00011,
    sub_or    = 5'b00100,
    sub_slli  = 5'b01000,
    sub_srli  = 5'b01001,
    sub_rotri = 5'b01011
  } sub_opcode_t;

  // how the raw immediate field is extended
  typedef enum logic [1:0] {
    imm_5_ze  = 2'b00,
    imm_15_se = 2'b01,
    imm_15_ze = 2'b10,
    imm_20_se = 2'b11
  } imm_kind_t;

  typedef enum logic {
    wb_alu       = 1'b0,
    wb_immediate = 1'b1
  } wb_source_t;

endpackage

// ==== execute_unit.sv ====
// immediate extension, operand select, alu and result register of the core, used inside cpu_core
`timescale 1ns/100ps
`include "cpu_macros.svh"

module execute_unit (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          execute_enable,
  input  cpu_pkg::opcode_t              operation,
  input  cpu_pkg::sub_opcode_t          sub_operation,
  input  logic [`CPU_IMM_WIDTH-1:0]     immediate_field,
  input  cpu_pkg::imm_kind_t            imm_kind,
  input  logic                          use_immediate,
  input  cpu_pkg::wb_source_t           wb_source,
  input  logic [`CPU_DATA_WIDTH-1:0]    read_data_a,
  input  logic [`CPU_DATA_WIDTH-1:0]    read_data_b,
  output logic [`CPU_DATA_WIDTH-1:0]    result
);

  logic [`CPU_DATA_WIDTH-1:0]     immediate;
  logic [`CPU_DATA_WIDTH-1:0]     operand_b;
  logic [`CPU_REG_ADDR_WIDTH-1:0] shift_amount;
  logic [2*`CPU_DATA_WIDTH-1:0]   rotate_pair;
  logic [`CPU_DATA_WIDTH-1:0]     alu_value;
  logic [`CPU_DATA_WIDTH-1:0]     next_result;

  always_comb begin
    unique case (imm_kind)
      cpu_pkg::imm_5_ze:
        immediate = {{(`CPU_DATA_WIDTH-5){1'b0}}, immediate_field[14:10]};
      cpu_pkg::imm_15_se:
        immediate = {{(`CPU_DATA_WIDTH-15){immediate_field[14]}}, immediate_field[14:0]};
      cpu_pkg::imm_15_ze:
        immediate = {{(`CPU_DATA_WIDTH-15){1'b0}}, immediate_field[14:0]};
      cpu_pkg::imm_20_se:
        immediate = {{(`CPU_DATA_WIDTH-20){immediate_field[19]}}, immediate_field};
    endcase
  end

  assign operand_b    = use_immediate ? immediate : read_data_b;
  assign shift_amount = operand_b[`CPU_REG_ADDR_WIDTH-1:0];
  // right rotate as the low half of the doubled word shifted down
  assign rotate_pair  = {read_data_a, read_data_a} >> shift_amount;

  always_comb begin
    case (operation)
      cpu_pkg::op_alu: begin
        case (sub_operation)
          cpu_pkg::sub_add:   alu_value = read_data_a + operand_b;
          cpu_pkg::sub_sub:   alu_value = read_data_a - operand_b;
          cpu_pkg::sub_and:   alu_value = read_data_a & operand_b;
          cpu_pkg::sub_xor:   alu_value = read_data_a ^ operand_b;
          cpu_pkg::sub_or:    alu_value = read_data_a | operand_b;
          cpu_pkg::sub_slli:  alu_value = read_data_a << shift_amount;
          cpu_pkg::sub_srli:  alu_value = read_data_a >> shift_amount;
          cpu_pkg::sub_rotri: alu_value = rotate_pair[`CPU_DATA_WIDTH-1:0];
          default:            alu_value = read_data_a;
        endcase
      end
      cpu_pkg::op_addi: alu_value = read_data_a + operand_b;
      cpu_pkg::op_ori:  alu_value = read_data_a | operand_b;
      cpu_pkg::op_xori: alu_value = read_data_a ^ operand_b;
      default:          alu_value = read_data_a;
    endcase
  end

  // movi bypasses the alu
  assign next_result = (wb_source == cpu_pkg::wb_immediate) ? immediate : alu_value;

  // captured at the edge that ends the execute state
  always_ff @(posedge clock) begin
    if (reset) begin
      result <= '0;
    end else if (execute_enable) begin
      result <= next_result;
    end
  end

endmodule

// ==== filelist.f ====
+incdir+.
cpu_pkg.sv
alu_controller.sv
register_file.sv
execute_unit.sv
cpu_core.sv
cpu_core_assert.sv
tb_cpu_core.sv

// ==== register_file.sv ====
// 32-entry register file with two combinational reads and one clocked write, used inside cpu_core
`timescale 1ns/100ps
`include "cpu_macros.svh"

module register_file (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           write_enable,
  input  logic [`CPU_REG_ADDR_WIDTH-1:0] read_address_a,
  input  logic [`CPU_REG_ADDR_WIDTH-1:0] read_address_b,
  input  logic [`CPU_REG_ADDR_WIDTH-1:0] write_address,
  input  logic [`CPU_DATA_WIDTH-1:0]     write_data,
  output logic [`CPU_DATA_WIDTH-1:0]     read_data_a,
  output logic [`CPU_DATA_WIDTH-1:0]     read_data_b
);

  logic [`CPU_DATA_WIDTH-1:0] registers [`CPU_REG_COUNT];

  // register zero is writable like any other
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `CPU_REG_COUNT; i++) begin
        registers[i] <= '0;
      end
    end else if (write_enable) begin
      registers[write_address] <= write_data;
    end
  end

  assign read_data_a = registers[read_address_a];
  assign read_data_b = registers[read_address_b];

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cpu_core -f filelist.f -o tb_cpu_core
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

output=$(./obj_dir/tb_cpu_core +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
  exit 0
fi
exit 1

// ==== tb_cpu_core.sv ====
// testbench for cpu_core, runs an instruction table against a register model and checks each write
`timescale 1ns/100ps
`include "cpu_macros.svh"

module tb_cpu_core;

  logic                           clock;
  logic                           reset;
  logic [`CPU_DATA_WIDTH-1:0]     instruction;
  logic                           fetch;
  logic [`CPU_DATA_WIDTH-1:0]     pc;
  logic                           write_enable;
  logic [`CPU_REG_ADDR_WIDTH-1:0] write_address;
  logic [`CPU_DATA_WIDTH-1:0]     write_data;

  logic [`CPU_DATA_WIDTH-1:0] table_word [$];
  bit                         table_write [$];
  logic [`CPU_DATA_WIDTH-1:0] model_regs [`CPU_REG_COUNT];
  logic [31:0]                rng_state = 32'h39b2_16dd;
  int                         error_count = 0;
  int                         failed_tests = 0;
  bit                         table_ready = 0;

  cpu_core DUT (
    .clock         (clock),
    .reset         (reset),
    .instruction   (instruction),
    .fetch         (fetch),
    .pc            (pc),
    .write_enable  (write_enable),
    .write_address (write_address),
    .write_data    (write_data)
  );

  always #2 clock = ~clock;

  function automatic logic [31:0] xorshift(input logic [31:0] value);
    logic [31:0] x;
    x = value;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [31:0] random_word();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // instruction encoders, bit 31 unused
  function automatic logic [31:0] alu_word(input logic [4:0] sub, input logic [4:0] rd,
                                           input logic [4:0] ra, input logic [4:0] rb);
    return {1'b0, cpu_pkg::op_alu, rd, ra, rb, 5'b00000, sub};
  endfunction

  function automatic logic [31:0] imm_word(input logic [5:0] op, input logic [4:0] rd,
                                           input logic [4:0] ra, input logic [14:0] imm);
    return {1'b0, op, rd, ra, imm};
  endfunction

  function automatic logic [31:0] movi_word(input logic [4:0] rd, input logic [19:0] imm);
    return {1'b0, cpu_pkg::op_movi, rd, imm};
  endfunction

  // value the ISA writes to the destination, from the model registers
  function automatic logic [31:0] model_result(input logic [31:0] word);
    cpu_pkg::opcode_t     op;
    cpu_pkg::sub_opcode_t sub;
    logic [31:0]          a;
    logic [31:0]          b;
    logic [4:0]           amount;
    logic [31:0]          value;
    op     = cpu_pkg::opcode_t'(word[30:25]);
    sub    = cpu_pkg::sub_opcode_t'(word[4:0]);
    a      = model_regs[word[19:15]];
    b      = model_regs[word[14:10]];
    amount = word[14:10];
    value  = a;
    case (op)
      cpu_pkg::op_alu: begin
        case (sub)
          cpu_pkg::sub_add:   value = a + b;
          cpu_pkg::sub_sub:   value = a - b;
          cpu_pkg::sub_and:   value = a & b;
          cpu_pkg::sub_or:    value = a | b;
          cpu_pkg::sub_xor:   value = a ^ b;
          cpu_pkg::sub_slli:  value = a << amount;
          cpu_pkg::sub_srli:  value = a >> amount;
          cpu_pkg::sub_rotri: value = (a >> amount) | (a << (6'd32 - {1'b0, amount}));
          default:            value = a;
        endcase
      end
      cpu_pkg::op_addi: value = a + {{17{word[14]}}, word[14:0]};
      cpu_pkg::op_ori:  value = a | {17'b0, word[14:0]};
      cpu_pkg::op_xori: value = a ^ {17'b0, word[14:0]};
      cpu_pkg::op_movi: value = {{12{word[19]}}, word[19:0]};
      default:          value = a;
    endcase
    return value;
  endfunction

  task automatic check_data(input string name, input logic [`CPU_DATA_WIDTH-1:0] actual,
                            input logic [`CPU_DATA_WIDTH-1:0] expected);
    if (actual !== expected) begin
      $display("ERROR %s: got %h, expected %h", name, actual, expected);
      error_count++;
    end
  endtask

  task automatic check_address(input string name, input logic [`CPU_REG_ADDR_WIDTH-1:0] actual,
                               input logic [`CPU_REG_ADDR_WIDTH-1:0] expected);
    if (actual !== expected) begin
      $display("ERROR %s: got %h, expected %h", name, actual, expected);
      error_count++;
    end
  endtask

  task automatic check_pc(input logic [`CPU_DATA_WIDTH-1:0] expected);
    check_data("pc", pc, expected);
  endtask

  task automatic check_write_strobe(input bit expected);
    if (write_enable !== expected) begin
      if (expected) begin
        $display("write_enable stayed low for an instruction that writes");
      end else begin
        $display("write_enable went high for an instruction that must not write");
      end
      error_count++;
    end
  endtask

  task automatic add_entry(input logic [31:0] word, input bit expect_write);
    table_word.push_back(word);
    table_write.push_back(expect_write);
  endtask

  task automatic load_random(input logic [4:0] rd);
    logic [31:0] r;
    r = random_word();
    add_entry(movi_word(rd, r[19:0]), 1'b1);
    add_entry(alu_word(cpu_pkg::sub_slli, rd, rd, 5'd12), 1'b1);
    add_entry(imm_word(cpu_pkg::op_addi, rd, rd, r[31:17]), 1'b1);
  endtask

  task automatic build_table();
    logic [31:0] r;
    logic [4:0]  amounts [5];
    add_entry(movi_word(5'd1, 20'h12345), 1'b1);
    add_entry(movi_word(5'd2, 20'h80f0f), 1'b1);
    add_entry(imm_word(cpu_pkg::op_addi, 5'd3, 5'd1, 15'h7fff), 1'b1);
    add_entry(imm_word(cpu_pkg::op_addi, 5'd4, 5'd1, 15'h0010), 1'b1);
    add_entry(imm_word(cpu_pkg::op_ori, 5'd5, 5'd2, 15'h4001), 1'b1);
    add_entry(imm_word(cpu_pkg::op_xori, 5'd6, 5'd2, 15'h7abc), 1'b1);
    load_random(5'd10);
    load_random(5'd11);
    add_entry(alu_word(cpu_pkg::sub_add, 5'd12, 5'd10, 5'd11), 1'b1);
    add_entry(alu_word(cpu_pkg::sub_sub, 5'd13, 5'd10, 5'd11), 1'b1);
    add_entry(alu_word(cpu_pkg::sub_and, 5'd14, 5'd10, 5'd11), 1'b1);
    add_entry(alu_word(cpu_pkg::sub_or, 5'd15, 5'd10, 5'd11), 1'b1);
    add_entry(alu_word(cpu_pkg::sub_xor, 5'd16, 5'd10, 5'd11), 1'b1);
    r = random_word();
    amounts[0] = 5'd0;
    amounts[1] = 5'd1;
    amounts[2] = 5'd31;
    amounts[3] = r[4:0];
    amounts[4] = r[12:8];
    for (int k = 0; k < 5; k++) begin
      add_entry(alu_word(cpu_pkg::sub_slli, 5'd20, 5'd10, amounts[k]), 1'b1);
      add_entry(alu_word(cpu_pkg::sub_srli, 5'd21, 5'd10, amounts[k]), 1'b1);
      add_entry(alu_word(cpu_pkg::sub_rotri, 5'd22, 5'd10, amounts[k]), 1'b1);
    end
    // undefined encodings, each followed by a copy that reads the destination back
    add_entry({1'b0, 6'b111111, 5'd12, 5'd10, 5'd11, 10'h000}, 1'b0);
    add_entry(imm_word(cpu_pkg::op_ori, 5'd23, 5'd12, 15'h0000), 1'b1);
    add_entry(alu_word(5'b11111, 5'd13, 5'd10, 5'd11), 1'b0);
    add_entry(imm_word(cpu_pkg::op_ori, 5'd24, 5'd13, 15'h0000), 1'b1);
  endtask

  task automatic run_entry(input int index);
    int          errors_before;
    logic [31:0] word;
    logic [31:0] expected;
    errors_before = error_count;
    word = table_word[index];
    @(posedge clock);
    #1;
    while (fetch !== 1'b1) begin
      @(posedge clock);
      #1;
    end
    instruction = word;
    check_pc(32'(index * 4));
    expected = model_result(word);
    // first edge ends fetch, second edge starts the write state
    repeat (2) @(posedge clock);
    #1;
    check_write_strobe(table_write[index]);
    if (table_write[index]) begin
      check_address("write_address", write_address, word[24:20]);
      check_data("write_data", write_data, expected);
      model_regs[word[24:20]] = expected;
    end
    if (error_count == errors_before) begin
      $display("test %0d instruction %h passed", index, word);
    end else begin
      $display("test %0d instruction %h failed", index, word);
      failed_tests++;
    end
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    instruction = '0;
    for (int r = 0; r < `CPU_REG_COUNT; r++) begin
      model_regs[r] = '0;
    end
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;
    if (fetch !== 1'b0 || write_enable !== 1'b0) begin
      $display("fetch or write_enable is not low after reset");
      error_count++;
    end
    for (int i = 0; i < table_word.size(); i++) begin
      run_entry(i);
    end
    $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
             table_word.size(), failed_tests, error_count, DUT.u_assert.failure_count);
    if (error_count == 0 && DUT.u_assert.failure_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // four cycles per instruction plus reset and margin
  initial begin
    wait (table_ready);
    #((table_word.size() * 4 + 16) * 4);
    $display("timeout: the instruction table did not finish in time");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule
